//--- include/exe_defines.svh
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

// Datapath and register file
`define EXE_XLEN 32
`define EXE_REG_PTR_W 5

// One restoring step per quotient bit
`define EXE_DIV_STEPS `EXE_XLEN

// Fault numbers reported on fault_num
`define EXE_FAULT_INVALID_INST 7'h14
`define EXE_FAULT_DIV_ZERO 7'h15

`endif

//--- hw/exe_pkg.sv
package exe_pkg;

	typedef enum logic [1:0] {
		UNIT_INT = 2'h0,
		UNIT_DIV = 2'h1,
		UNIT_LDST = 2'h2
	} unit_e;

	// Command field, decoded per unit
	typedef logic [3:0] cmd_e;

	// Integer unit
	localparam cmd_e CMD_ADD = 4'h0;
	localparam cmd_e CMD_SUB = 4'h1;
	localparam cmd_e CMD_AND = 4'h2;
	localparam cmd_e CMD_OR = 4'h3;
	localparam cmd_e CMD_XOR = 4'h4;
	localparam cmd_e CMD_SHL = 4'h5;
	localparam cmd_e CMD_SHR = 4'h6;
	localparam cmd_e CMD_SAR = 4'h7;
	localparam cmd_e CMD_MUL = 4'h8;

	// Divider
	localparam cmd_e CMD_UDIV = 4'h0;
	localparam cmd_e CMD_UMOD = 4'h1;
	localparam cmd_e CMD_SDIV = 4'h2;
	localparam cmd_e CMD_SMOD = 4'h3;

	// Load/store
	localparam cmd_e CMD_LDB = 4'h0;
	localparam cmd_e CMD_LDH = 4'h1;
	localparam cmd_e CMD_LDW = 4'h2;
	localparam cmd_e CMD_STB = 4'h4;
	localparam cmd_e CMD_STH = 4'h5;
	localparam cmd_e CMD_STW = 4'h6;

	typedef enum logic [1:0] {
		ORDER_BYTE = 2'h0,
		ORDER_HALF = 2'h1,
		ORDER_WORD = 2'h2
	} order_e;

	typedef enum logic [1:0] {
		ST_NORMAL = 2'h0,
		ST_DIV_WAIT = 2'h1,
		ST_LOAD = 2'h2,
		ST_STORE = 2'h3
	} state_e;

	typedef struct packed {
		logic sign;
		logic overflow;
		logic carry;
		logic parity;
		logic zero;
	} flags_t;

endpackage

//--- hw/exe_ifs.sv
`timescale 1ns/10ps
`default_nettype none
`include "exe_defines.svh"

// Latest result, also the forwarding source
interface result_if;
	logic valid;
	logic [`EXE_REG_PTR_W-1:0] dest;
	logic writeback;
	logic [`EXE_XLEN-1:0] data;

	modport driver(output valid, dest, writeback, data);
	modport reader(input valid, dest, writeback, data);
endinterface

// One division in flight at a time
interface div_if;
	logic start;
	logic is_signed;
	logic want_rem;
	logic [`EXE_XLEN-1:0] dividend;
	logic [`EXE_XLEN-1:0] divisor;
	logic done;
	logic [`EXE_XLEN-1:0] quotient;
	logic [`EXE_XLEN-1:0] remainder;

	modport master(
		output start, is_signed, want_rem, dividend, divisor,
		input done, quotient, remainder
	);
	modport slave(
		input start, is_signed, want_rem, dividend, divisor,
		output done, quotient, remainder
	);
endinterface

`default_nettype wire

//--- hw/operand_forward.sv
`timescale 1ns/10ps
`default_nettype none
`include "exe_defines.svh"

module operand_forward(
	result_if.reader fwd,
	input logic [`EXE_REG_PTR_W-1:0] src0_ptr,
	input logic [`EXE_REG_PTR_W-1:0] src1_ptr,
	input logic src1_imm,
	input logic [`EXE_XLEN-1:0] src0_in,
	input logic [`EXE_XLEN-1:0] src1_in,
	output logic [`EXE_XLEN-1:0] src0,
	output logic [`EXE_XLEN-1:0] src1
);

	logic fwd_live;

	// Only a result that will reach the register file counts
	assign fwd_live = fwd.valid && fwd.writeback;

	always_comb begin
		if (fwd_live && (src0_ptr == fwd.dest)) begin
			src0 = fwd.data;
		end
		else begin
			src0 = src0_in;
		end
	end

	// Immediate in source 1 is never a register read
	always_comb begin
		if (fwd_live && !src1_imm && (src1_ptr == fwd.dest)) begin
			src1 = fwd.data;
		end
		else begin
			src1 = src1_in;
		end
	end

endmodule

`default_nettype wire

//--- hw/int_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "exe_defines.svh"

module int_unit(
	input exe_pkg::cmd_e cmd,
	input logic [`EXE_XLEN-1:0] a,
	input logic [`EXE_XLEN-1:0] b,
	output logic [`EXE_XLEN-1:0] result,
	output exe_pkg::flags_t flags
);

	localparam int MSB = `EXE_XLEN - 1;
	localparam int SH_W = $clog2(`EXE_XLEN);

	logic [`EXE_XLEN:0] sum;
	logic [`EXE_XLEN:0] diff;
	logic [2*`EXE_XLEN-1:0] prod;
	logic [SH_W-1:0] shamt;
	logic carry;
	logic overflow;

	// Extra top bit holds carry out and borrow
	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};
	assign prod = a * b;
	assign shamt = b[SH_W-1:0];

	always_comb begin
		carry = 1'b0;
		overflow = 1'b0;
		case (cmd)
			exe_pkg::CMD_ADD: begin
				result = sum[MSB:0];
				carry = sum[`EXE_XLEN];
				overflow = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
			end
			exe_pkg::CMD_SUB: begin
				result = diff[MSB:0];
				carry = diff[`EXE_XLEN];
				overflow = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
			end
			exe_pkg::CMD_AND: begin
				result = a & b;
			end
			exe_pkg::CMD_OR: begin
				result = a | b;
			end
			exe_pkg::CMD_XOR: begin
				result = a ^ b;
			end
			exe_pkg::CMD_SHL: begin
				result = a << shamt;
			end
			exe_pkg::CMD_SHR: begin
				result = a >> shamt;
			end
			exe_pkg::CMD_SAR: begin
				result = $signed(a) >>> shamt;
			end
			exe_pkg::CMD_MUL: begin
				// low word only, bit 32 goes to carry
				result = prod[MSB:0];
				carry = prod[`EXE_XLEN];
			end
			default: begin
				result = '0;
			end
		endcase
	end

	assign flags.sign = result[MSB];
	assign flags.overflow = overflow;
	assign flags.carry = carry;
	assign flags.parity = result[0];
	assign flags.zero = (result == '0);

endmodule

`default_nettype wire

//--- hw/radix2_divider.sv
`timescale 1ns/10ps
`default_nettype none
`include "exe_defines.svh"

module radix2_divider(
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	div_if.slave div
);

	localparam int MSB = `EXE_XLEN - 1;
	localparam int CNT_W = $clog2(`EXE_DIV_STEPS + 1);

	logic b_busy;
	logic b_fix;
	logic b_done;
	logic [CNT_W-1:0] b_cnt;
	logic [`EXE_XLEN-1:0] b_rem;
	logic [`EXE_XLEN-1:0] b_quo;
	logic [`EXE_XLEN-1:0] b_dvs;
	logic b_neg_q;
	logic b_neg_r;
	logic [`EXE_XLEN-1:0] b_quotient;
	logic [`EXE_XLEN-1:0] b_remainder;
	logic [`EXE_XLEN-1:0] dvd_mag;
	logic [`EXE_XLEN-1:0] dvs_mag;
	logic [`EXE_XLEN:0] partial;
	logic [`EXE_XLEN:0] trial;

	assign dvd_mag = (div.is_signed && div.dividend[MSB]) ? -div.dividend : div.dividend;
	assign dvs_mag = (div.is_signed && div.divisor[MSB]) ? -div.divisor : div.divisor;

	// Shift in next dividend bit, borrow means restore
	assign partial = {b_rem, b_quo[MSB]};
	assign trial = partial - {1'b0, b_dvs};

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_busy <= 1'b0;
			b_fix <= 1'b0;
			b_done <= 1'b0;
			b_cnt <= '0;
		end
		else begin
			b_done <= 1'b0;
			if (flush) begin
				b_busy <= 1'b0;
				b_fix <= 1'b0;
			end
			else if (div.start) begin
				b_busy <= 1'b1;
				b_cnt <= '0;
			end
			else if (b_fix) begin
				b_busy <= 1'b0;
				b_fix <= 1'b0;
				b_done <= 1'b1;
			end
			else if (b_busy) begin
				b_cnt <= b_cnt + 1'b1;
				if (b_cnt == CNT_W'(`EXE_DIV_STEPS - 1)) begin
					b_fix <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (div.start) begin
			b_rem <= '0;
			b_quo <= dvd_mag;
			b_dvs <= dvs_mag;
			b_neg_q <= div.is_signed && (div.dividend[MSB] ^ div.divisor[MSB]);
			b_neg_r <= div.is_signed && div.dividend[MSB];
		end
		else if (b_busy && !b_fix) begin
			b_rem <= trial[`EXE_XLEN] ? partial[MSB:0] : trial[MSB:0];
			b_quo <= {b_quo[MSB-1:0], !trial[`EXE_XLEN]};
		end
		// Remainder follows the dividend sign
		if (b_fix) begin
			b_quotient <= b_neg_q ? -b_quo : b_quo;
			b_remainder <= b_neg_r ? -b_rem : b_rem;
		end
	end

	assign div.done = b_done;
	assign div.quotient = b_quotient;
	assign div.remainder = b_remainder;

	a_no_start_while_busy: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		div.start |-> !b_busy
	) else $error("divider started while busy");

endmodule

`default_nettype wire

//--- hw/exe_control.sv
`timescale 1ns/10ps
`default_nettype none
`include "exe_defines.svh"

module exe_control(
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic in_valid,
	input exe_pkg::unit_e in_unit,
	input exe_pkg::cmd_e in_cmd,
	input logic [`EXE_REG_PTR_W-1:0] in_dest,
	input logic in_writeback,
	input logic in_flags_writeback,
	input logic in_invalid_inst,
	input logic [`EXE_XLEN-1:0] src0,
	input logic [`EXE_XLEN-1:0] src1,
	input logic [`EXE_XLEN-1:0] alu_result,
	input exe_pkg::flags_t alu_flags,
	output logic stall,
	output exe_pkg::flags_t flags,
	output logic fault_valid,
	output logic [6:0] fault_num,
	result_if.driver res,
	div_if.master div,
	output logic mem_req,
	input logic mem_busy,
	output logic mem_rw,
	output exe_pkg::order_e mem_order,
	output logic [`EXE_XLEN-1:0] mem_addr,
	output logic [`EXE_XLEN-1:0] mem_wdata,
	input logic mem_ack,
	input logic [`EXE_XLEN-1:0] mem_rdata
);

	exe_pkg::state_e b_state;
	exe_pkg::flags_t b_flags;
	logic b_valid;
	logic b_fault_valid;
	logic b_mem_req;
	logic [`EXE_REG_PTR_W-1:0] b_dest;
	logic b_writeback;
	logic [`EXE_XLEN-1:0] b_data;
	logic [6:0] b_fault_num;
	logic b_div_rem;
	logic accept;
	logic fault_inv;
	logic fault_dz;
	logic cmd_signed;
	logic cmd_rem;
	logic is_store;
	exe_pkg::order_e ldst_order;
	logic [`EXE_XLEN-1:0] load_shifted;
	logic [`EXE_XLEN-1:0] load_data;

	assign stall = (b_state != exe_pkg::ST_NORMAL);
	assign accept = in_valid && !stall && !flush;
	assign fault_inv = in_invalid_inst;
	assign fault_dz = (in_unit == exe_pkg::UNIT_DIV) && (src1 == '0);

	assign cmd_signed = (in_cmd == exe_pkg::CMD_SDIV) || (in_cmd == exe_pkg::CMD_SMOD);
	assign cmd_rem = (in_cmd == exe_pkg::CMD_UMOD) || (in_cmd == exe_pkg::CMD_SMOD);

	always_comb begin
		is_store = 1'b0;
		ldst_order = exe_pkg::ORDER_WORD;
		case (in_cmd)
			exe_pkg::CMD_LDB: ldst_order = exe_pkg::ORDER_BYTE;
			exe_pkg::CMD_LDH: ldst_order = exe_pkg::ORDER_HALF;
			exe_pkg::CMD_LDW: ldst_order = exe_pkg::ORDER_WORD;
			exe_pkg::CMD_STB: begin
				is_store = 1'b1;
				ldst_order = exe_pkg::ORDER_BYTE;
			end
			exe_pkg::CMD_STH: begin
				is_store = 1'b1;
				ldst_order = exe_pkg::ORDER_HALF;
			end
			exe_pkg::CMD_STW: begin
				is_store = 1'b1;
				ldst_order = exe_pkg::ORDER_WORD;
			end
			default: ldst_order = exe_pkg::ORDER_WORD;
		endcase
	end

	// Address is held until ack, so its low bits pick the lane
	assign load_shifted = mem_rdata >> {mem_addr[1:0], 3'b000};

	always_comb begin
		load_data = '0;
		case (mem_order)
			exe_pkg::ORDER_BYTE: load_data[7:0] = load_shifted[7:0];
			exe_pkg::ORDER_HALF: load_data[15:0] = load_shifted[15:0];
			default: load_data = load_shifted;
		endcase
	end

	// Start only from the normal state
	assign div.start = accept && (in_unit == exe_pkg::UNIT_DIV) && !fault_inv && !fault_dz;
	assign div.is_signed = cmd_signed;
	assign div.want_rem = (b_state == exe_pkg::ST_DIV_WAIT) ? b_div_rem : cmd_rem;
	assign div.dividend = src0;
	assign div.divisor = src1;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_state <= exe_pkg::ST_NORMAL;
			b_flags <= '0;
			b_valid <= 1'b0;
			b_fault_valid <= 1'b0;
			b_mem_req <= 1'b0;
		end
		else if (flush) begin
			b_state <= exe_pkg::ST_NORMAL;
			b_valid <= 1'b0;
			b_fault_valid <= 1'b0;
			b_mem_req <= 1'b0;
		end
		else begin
			b_valid <= 1'b0;
			b_fault_valid <= 1'b0;
			case (b_state)
				exe_pkg::ST_NORMAL: begin
					if (accept && (fault_inv || fault_dz)) begin
						b_fault_valid <= 1'b1;
					end
					else if (accept) begin
						case (in_unit)
							exe_pkg::UNIT_INT: begin
								b_valid <= 1'b1;
								if (in_flags_writeback) begin
									b_flags <= alu_flags;
								end
							end
							exe_pkg::UNIT_DIV: b_state <= exe_pkg::ST_DIV_WAIT;
							exe_pkg::UNIT_LDST: begin
								b_mem_req <= 1'b1;
								b_state <= is_store ? exe_pkg::ST_STORE : exe_pkg::ST_LOAD;
							end
							default: b_valid <= 1'b0;
						endcase
					end
				end
				exe_pkg::ST_DIV_WAIT: begin
					if (div.done) begin
						b_valid <= 1'b1;
						b_state <= exe_pkg::ST_NORMAL;
					end
				end
				default: begin
					// Request is taken on the first cycle without busy
					if (b_mem_req && !mem_busy) begin
						b_mem_req <= 1'b0;
					end
					if (mem_ack) begin
						b_valid <= (b_state == exe_pkg::ST_LOAD);
						b_state <= exe_pkg::ST_NORMAL;
					end
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			b_dest <= in_dest;
			b_writeback <= in_writeback;
			b_div_rem <= cmd_rem;
			b_fault_num <= fault_inv ? `EXE_FAULT_INVALID_INST : `EXE_FAULT_DIV_ZERO;
			if (in_unit == exe_pkg::UNIT_INT) begin
				b_data <= alu_result;
			end
			if (in_unit == exe_pkg::UNIT_LDST) begin
				mem_rw <= is_store;
				mem_order <= ldst_order;
				mem_addr <= src0 + src1;
				mem_wdata <= src0;
			end
		end
		if ((b_state == exe_pkg::ST_DIV_WAIT) && div.done) begin
			b_data <= div.want_rem ? div.remainder : div.quotient;
		end
		if ((b_state == exe_pkg::ST_LOAD) && mem_ack) begin
			b_data <= load_data;
		end
	end

	assign res.valid = b_valid;
	assign res.dest = b_dest;
	assign res.writeback = b_writeback;
	assign res.data = b_data;
	assign flags = b_flags;
	assign fault_valid = b_fault_valid;
	assign fault_num = b_fault_num;
	assign mem_req = b_mem_req;

	a_req_in_mem_state: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		mem_req |-> (b_state inside {exe_pkg::ST_LOAD, exe_pkg::ST_STORE})
	) else $error("mem_req outside load/store");

	a_addr_held_busy: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		(mem_req && mem_busy && !flush) |=> (mem_req && $stable(mem_addr))
	) else $error("mem request changed under busy");

endmodule

`default_nettype wire

//--- hw/exe_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "exe_defines.svh"

module exe_stage(
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic in_valid,
	input exe_pkg::unit_e in_unit,
	input exe_pkg::cmd_e in_cmd,
	input logic [`EXE_REG_PTR_W-1:0] in_dest,
	input logic in_writeback,
	input logic in_flags_writeback,
	input logic in_invalid_inst,
	input logic [`EXE_XLEN-1:0] in_src0,
	input logic [`EXE_XLEN-1:0] in_src1,
	input logic [`EXE_REG_PTR_W-1:0] in_src0_ptr,
	input logic [`EXE_REG_PTR_W-1:0] in_src1_ptr,
	input logic in_src1_imm,
	output logic stall,
	output logic mem_req,
	input logic mem_busy,
	output logic mem_rw,
	output exe_pkg::order_e mem_order,
	output logic [`EXE_XLEN-1:0] mem_addr,
	output logic [`EXE_XLEN-1:0] mem_wdata,
	input logic mem_ack,
	input logic [`EXE_XLEN-1:0] mem_rdata,
	output logic out_valid,
	output logic [`EXE_XLEN-1:0] out_data,
	output logic [`EXE_REG_PTR_W-1:0] out_dest,
	output logic out_writeback,
	output exe_pkg::flags_t flags,
	output logic fault_valid,
	output logic [6:0] fault_num
);

	logic [`EXE_XLEN-1:0] src0;
	logic [`EXE_XLEN-1:0] src1;
	logic [`EXE_XLEN-1:0] alu_result;
	exe_pkg::flags_t alu_flags;

	result_if res_bus();
	div_if div_bus();

	operand_forward u_fwd(
		.fwd(res_bus.reader),
		.src0_ptr(in_src0_ptr),
		.src1_ptr(in_src1_ptr),
		.src1_imm(in_src1_imm),
		.src0_in(in_src0),
		.src1_in(in_src1),
		.src0(src0),
		.src1(src1)
	);

	int_unit u_int(
		.cmd(in_cmd),
		.a(src0),
		.b(src1),
		.result(alu_result),
		.flags(alu_flags)
	);

	radix2_divider u_div(
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.div(div_bus.slave)
	);

	exe_control u_ctrl(
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.in_valid(in_valid),
		.in_unit(in_unit),
		.in_cmd(in_cmd),
		.in_dest(in_dest),
		.in_writeback(in_writeback),
		.in_flags_writeback(in_flags_writeback),
		.in_invalid_inst(in_invalid_inst),
		.src0(src0),
		.src1(src1),
		.alu_result(alu_result),
		.alu_flags(alu_flags),
		.stall(stall),
		.flags(flags),
		.fault_valid(fault_valid),
		.fault_num(fault_num),
		.res(res_bus.driver),
		.div(div_bus.master),
		.mem_req(mem_req),
		.mem_busy(mem_busy),
		.mem_rw(mem_rw),
		.mem_order(mem_order),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

	// Writeback record
	assign out_valid = res_bus.valid;
	assign out_data = res_bus.data;
	assign out_dest = res_bus.dest;
	assign out_writeback = res_bus.writeback;

endmodule

`default_nettype wire

//--- tb/exe_tb_pkg.sv
`include "exe_defines.svh"

package exe_tb_pkg;

	localparam longint S32_MAX = 64'sd2147483647;
	localparam longint S32_MIN = -64'sd2147483648;

	typedef struct packed {
		logic [`EXE_XLEN-1:0] data;
		logic [`EXE_REG_PTR_W-1:0] dest;
		logic wb;
		exe_pkg::flags_t flags;
	} expect_t;

	// Last accepted writeback, visible to the very next issue only
	expect_t last;
	logic last_live;
	exe_pkg::flags_t model_flags;

	function automatic logic [`EXE_XLEN-1:0] forward_operand(
			input logic [`EXE_REG_PTR_W-1:0] ptr, input logic [`EXE_XLEN-1:0] value,
			input logic imm);
		if (last_live && last.wb && !imm && (ptr == last.dest)) begin
			return last.data;
		end
		return value;
	endfunction

	function automatic logic [`EXE_XLEN-1:0] int_result(input exe_pkg::cmd_e cmd,
			input logic [`EXE_XLEN-1:0] a, input logic [`EXE_XLEN-1:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (cmd)
			exe_pkg::CMD_ADD: return a + b;
			exe_pkg::CMD_SUB: return a - b;
			exe_pkg::CMD_AND: return a & b;
			exe_pkg::CMD_OR: return a | b;
			exe_pkg::CMD_XOR: return a ^ b;
			exe_pkg::CMD_SHL: return a << sh;
			exe_pkg::CMD_SHR: return a >> sh;
			exe_pkg::CMD_SAR: return $signed(a) >>> sh;
			exe_pkg::CMD_MUL: return a * b;
			default: return '0;
		endcase
	endfunction

	function automatic exe_pkg::flags_t int_flags(input exe_pkg::cmd_e cmd,
			input logic [`EXE_XLEN-1:0] a, input logic [`EXE_XLEN-1:0] b,
			input logic [`EXE_XLEN-1:0] r);
		exe_pkg::flags_t f;
		longint s;
		logic [63:0] wide;
		f = '0;
		f.sign = r[31];
		f.parity = r[0];
		f.zero = (r == 0);
		case (cmd)
			exe_pkg::CMD_ADD: begin
				wide = {32'h0, a} + {32'h0, b};
				s = longint'($signed(a)) + longint'($signed(b));
				f.carry = wide[32];
				f.overflow = (s > S32_MAX) || (s < S32_MIN);
			end
			exe_pkg::CMD_SUB: begin
				s = longint'($signed(a)) - longint'($signed(b));
				// Borrow
				f.carry = (a < b);
				f.overflow = (s > S32_MAX) || (s < S32_MIN);
			end
			exe_pkg::CMD_MUL: begin
				wide = {32'h0, a} * {32'h0, b};
				f.carry = wide[32];
			end
			default: f.carry = 1'b0;
		endcase
		return f;
	endfunction

	function automatic logic [`EXE_XLEN-1:0] div_result(input exe_pkg::cmd_e cmd,
			input logic [`EXE_XLEN-1:0] a, input logic [`EXE_XLEN-1:0] b);
		longint sa;
		longint sb;
		logic [63:0] q;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		case (cmd)
			exe_pkg::CMD_UDIV: return a / b;
			exe_pkg::CMD_UMOD: return a % b;
			exe_pkg::CMD_SDIV: q = sa / sb;
			default: q = sa % sb;
		endcase
		return q[31:0];
	endfunction

	function automatic logic [`EXE_XLEN-1:0] load_extract(input logic [`EXE_XLEN-1:0] word,
			input logic [1:0] off, input exe_pkg::order_e order);
		logic [`EXE_XLEN-1:0] w;
		w = word >> (8 * off);
		case (order)
			exe_pkg::ORDER_BYTE: return {24'h0, w[7:0]};
			exe_pkg::ORDER_HALF: return {16'h0, w[15:0]};
			default: return w;
		endcase
	endfunction

endpackage

//--- tb/tb_exe.sv
`timescale 1ns/10ps
`default_nettype none
`include "exe_defines.svh"

module tb_exe;

	localparam int CLK_PERIOD = 40;
	localparam int N_INT = 200;
	localparam int N_DIV = 24;
	localparam int N_MEM = 16;
	localparam int N_FLUSH = 4;
	// Memory and flush rounds each issue two instructions
	localparam int N_ISSUES = N_INT + N_DIV + 2 * N_MEM + 3 + 2 * N_FLUSH;

	logic iCLOCK;
	logic inRESET;
	logic flush;
	logic in_valid;
	exe_pkg::unit_e in_unit;
	exe_pkg::cmd_e in_cmd;
	logic [`EXE_REG_PTR_W-1:0] in_dest;
	logic in_writeback;
	logic in_flags_writeback;
	logic in_invalid_inst;
	logic [`EXE_XLEN-1:0] in_src0;
	logic [`EXE_XLEN-1:0] in_src1;
	logic [`EXE_REG_PTR_W-1:0] in_src0_ptr;
	logic [`EXE_REG_PTR_W-1:0] in_src1_ptr;
	logic in_src1_imm;
	logic stall;
	logic mem_req;
	logic mem_busy;
	logic mem_rw;
	exe_pkg::order_e mem_order;
	logic [`EXE_XLEN-1:0] mem_addr;
	logic [`EXE_XLEN-1:0] mem_wdata;
	logic mem_ack;
	logic [`EXE_XLEN-1:0] mem_rdata;
	logic out_valid;
	logic [`EXE_XLEN-1:0] out_data;
	logic [`EXE_REG_PTR_W-1:0] out_dest;
	logic out_writeback;
	exe_pkg::flags_t flags;
	logic fault_valid;
	logic [6:0] fault_num;

	logic [`EXE_XLEN-1:0] mem [0:255];
	int checks;
	int errors;

	exe_stage dut0(.*);

	initial begin
		iCLOCK = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;
		end
	end

	initial begin
		#(N_ISSUES * 60 * CLK_PERIOD);
		$display("Watchdog expired before all tests completed");
		$display("Test failed");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic drive_issue(input exe_pkg::unit_e unit, input exe_pkg::cmd_e cmd,
			input logic [4:0] dest, input logic [31:0] s0, input logic [31:0] s1);
		in_valid = 1'b1;
		in_unit = unit;
		in_cmd = cmd;
		in_dest = dest;
		in_src0 = s0;
		in_src1 = s1;
	endtask

	task automatic go_idle();
		in_valid = 1'b0;
		in_invalid_inst = 1'b0;
		exe_tb_pkg::last_live = 1'b0;
		@(negedge iCLOCK);
	endtask

	task automatic await_result(input int limit);
		int waited;
		waited = 0;
		while (!out_valid && waited < limit) begin
			check_value("stall", stall, 1'b1);
			@(negedge iCLOCK);
			waited++;
		end
		if (!out_valid) begin
			errors++;
			$display("No result arrived within %0d cycles", limit);
		end
	endtask

	task automatic await_ready(input int limit);
		int waited;
		waited = 0;
		while (stall && waited < limit) begin
			check_value("out_valid", out_valid, 1'b0);
			@(negedge iCLOCK);
			waited++;
		end
		if (stall) begin
			errors++;
			$display("Stall did not clear within %0d cycles", limit);
		end
	endtask

	// Back-to-back integer issues with forced pointer matches
	task automatic integer_burst(input int count);
		exe_tb_pkg::expect_t exp;
		exe_pkg::cmd_e cmd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] s0;
		logic [31:0] s1;
		for (int i = 0; i <= count; i++) begin
			if (i > 0) begin
				check_value("out_valid", out_valid, 1'b1);
				check_value("out_data", out_data, exp.data);
				check_value("out_dest", out_dest, exp.dest);
				check_value("out_writeback", out_writeback, exp.wb);
				check_value("flags", flags, exp.flags);
				exe_tb_pkg::last = exp;
				exe_tb_pkg::last_live = 1'b1;
			end
			if (i == count) begin
				go_idle();
			end
			else begin
				in_src0_ptr = $urandom_range(0, 1) ? exe_tb_pkg::last.dest : $urandom_range(0, 31);
				in_src1_ptr = $urandom_range(0, 1) ? exe_tb_pkg::last.dest : $urandom_range(0, 31);
				in_src1_imm = ($urandom_range(0, 3) == 0);
				in_writeback = ($urandom_range(0, 3) != 0);
				in_flags_writeback = ($urandom_range(0, 3) != 0);
				s0 = $urandom;
				s1 = ($urandom_range(0, 7) == 0) ? s0 : $urandom;
				a = exe_tb_pkg::forward_operand(in_src0_ptr, s0, 1'b0);
				b = exe_tb_pkg::forward_operand(in_src1_ptr, s1, in_src1_imm);
				cmd = $urandom_range(0, 8);
				exp.data = exe_tb_pkg::int_result(cmd, a, b);
				exp.dest = $urandom_range(0, 31);
				exp.wb = in_writeback;
				if (in_flags_writeback) begin
					exe_tb_pkg::model_flags = exe_tb_pkg::int_flags(cmd, a, b, exp.data);
				end
				exp.flags = exe_tb_pkg::model_flags;
				drive_issue(exe_pkg::UNIT_INT, cmd, exp.dest, s0, s1);
				@(negedge iCLOCK);
			end
		end
	endtask

	task automatic divide_once(input exe_pkg::cmd_e cmd, input logic [31:0] a,
			input logic [31:0] b);
		logic [31:0] exp_data;
		logic [4:0] dest;
		dest = $urandom_range(0, 31);
		exp_data = exe_tb_pkg::div_result(cmd, a, b);
		in_writeback = 1'b1;
		in_flags_writeback = 1'b1;
		drive_issue(exe_pkg::UNIT_DIV, cmd, dest, a, b);
		@(negedge iCLOCK);
		in_valid = 1'b0;
		await_result(`EXE_DIV_STEPS + 8);
		check_value("out_data", out_data, exp_data);
		check_value("out_dest", out_dest, dest);
		check_value("flags", flags, exe_tb_pkg::model_flags);
		go_idle();
	endtask

	task automatic store_then_load();
		logic [31:0] base;
		logic [31:0] word;
		logic [31:0] s0;
		logic [1:0] off;
		logic [4:0] dest;
		exe_pkg::order_e order;
		base = $urandom_range(0, 255) * 4;
		word = $urandom;
		// Store data is src0 and the address is src0 plus src1
		drive_issue(exe_pkg::UNIT_LDST, exe_pkg::CMD_STW, 5'd0, word, base - word);
		@(negedge iCLOCK);
		in_valid = 1'b0;
		await_ready(20);
		check_value("out_valid", out_valid, 1'b0);
		go_idle();
		order = exe_pkg::order_e'($urandom_range(0, 2));
		case (order)
			exe_pkg::ORDER_BYTE: off = $urandom_range(0, 3);
			exe_pkg::ORDER_HALF: off = $urandom_range(0, 1) * 2;
			default: off = 2'd0;
		endcase
		dest = $urandom_range(0, 31);
		s0 = $urandom;
		drive_issue(exe_pkg::UNIT_LDST, exe_pkg::cmd_e'(order), dest, s0, base + off - s0);
		@(negedge iCLOCK);
		in_valid = 1'b0;
		await_result(20);
		check_value("out_data", out_data, exe_tb_pkg::load_extract(word, off, order));
		check_value("out_dest", out_dest, dest);
		go_idle();
	endtask

	task automatic check_fault(input logic [6:0] num);
		check_value("fault_valid", fault_valid, 1'b1);
		check_value("fault_num", fault_num, num);
		check_value("out_valid", out_valid, 1'b0);
		check_value("flags", flags, exe_tb_pkg::model_flags);
	endtask

	task automatic fault_cases();
		logic [31:0] a;
		in_flags_writeback = 1'b1;
		drive_issue(exe_pkg::UNIT_DIV, exe_pkg::CMD_SDIV, 5'd3, $urandom, 32'h0);
		@(negedge iCLOCK);
		in_valid = 1'b0;
		check_fault(`EXE_FAULT_DIV_ZERO);
		go_idle();
		// Invalid mark wins over a zero divisor
		in_invalid_inst = 1'b1;
		drive_issue(exe_pkg::UNIT_DIV, exe_pkg::CMD_UDIV, 5'd4, $urandom, 32'h0);
		@(negedge iCLOCK);
		in_valid = 1'b0;
		in_invalid_inst = 1'b0;
		check_fault(`EXE_FAULT_INVALID_INST);
		go_idle();
		// Faulted integer add whose flags would differ from the current ones
		a = 32'h7fffffff;
		if (exe_tb_pkg::int_flags(exe_pkg::CMD_ADD, a, 32'h1, a + 32'h1)
				== exe_tb_pkg::model_flags) begin
			a = 32'hffffffff;
		end
		in_invalid_inst = 1'b1;
		drive_issue(exe_pkg::UNIT_INT, exe_pkg::CMD_ADD, 5'd5, a, 32'h1);
		@(negedge iCLOCK);
		in_valid = 1'b0;
		in_invalid_inst = 1'b0;
		check_fault(`EXE_FAULT_INVALID_INST);
		go_idle();
	endtask

	task automatic flush_division();
		logic [31:0] a;
		logic [31:0] b;
		int hold;
		drive_issue(exe_pkg::UNIT_DIV, exe_pkg::CMD_UDIV, 5'd7, $urandom, $urandom_range(1, 999));
		@(negedge iCLOCK);
		in_valid = 1'b0;
		hold = $urandom_range(0, `EXE_DIV_STEPS);
		repeat (hold) @(negedge iCLOCK);
		check_value("stall", stall, 1'b1);
		flush = 1'b1;
		@(negedge iCLOCK);
		flush = 1'b0;
		check_value("stall", stall, 1'b0);
		repeat (`EXE_DIV_STEPS + 4) begin
			check_value("out_valid", out_valid, 1'b0);
			@(negedge iCLOCK);
		end
		a = $urandom;
		b = $urandom;
		in_flags_writeback = 1'b1;
		exe_tb_pkg::model_flags = exe_tb_pkg::int_flags(exe_pkg::CMD_ADD, a, b, a + b);
		drive_issue(exe_pkg::UNIT_INT, exe_pkg::CMD_ADD, 5'd9, a, b);
		@(negedge iCLOCK);
		in_valid = 1'b0;
		check_value("out_valid", out_valid, 1'b1);
		check_value("out_data", out_data, a + b);
		check_value("flags", flags, exe_tb_pkg::model_flags);
		go_idle();
	endtask

	// Memory responder with random busy and ack delay
	initial begin : memory_model
		int busy_cycles;
		int ack_delay;
		logic [7:0] idx;
		logic [31:0] held_addr;
		for (int i = 0; i < 256; i++) begin
			mem[i] = (i * 32'h9e3779b9) ^ 32'h5a5a0000;
		end
		forever begin
			@(negedge iCLOCK);
			if (mem_req) begin
				held_addr = mem_addr;
				busy_cycles = $urandom_range(0, 3);
				repeat (busy_cycles) begin
					mem_busy = 1'b1;
					@(negedge iCLOCK);
					check_value("mem_req", mem_req, 1'b1);
					check_value("mem_addr", mem_addr, held_addr);
				end
				mem_busy = 1'b0;
				@(negedge iCLOCK);
				check_value("mem_req", mem_req, 1'b0);
				idx = held_addr[9:2];
				if (mem_rw) begin
					mem[idx] = mem_wdata;
				end
				ack_delay = $urandom_range(0, 3);
				repeat (ack_delay) @(negedge iCLOCK);
				mem_rdata = mem[idx];
				mem_ack = 1'b1;
				@(negedge iCLOCK);
				mem_ack = 1'b0;
			end
		end
	end

	initial begin : stimulus
		logic [31:0] a;
		logic [31:0] b;
		void'($urandom(32'hfc1));
		checks = 0;
		errors = 0;
		flush = 1'b0;
		in_valid = 1'b0;
		in_unit = exe_pkg::UNIT_INT;
		in_cmd = '0;
		in_dest = '0;
		in_writeback = 1'b0;
		in_flags_writeback = 1'b0;
		in_invalid_inst = 1'b0;
		in_src0 = '0;
		in_src1 = '0;
		in_src0_ptr = '0;
		in_src1_ptr = '0;
		in_src1_imm = 1'b0;
		mem_busy = 1'b0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		exe_tb_pkg::model_flags = '0;
		exe_tb_pkg::last = '0;
		exe_tb_pkg::last_live = 1'b0;
		inRESET = 1'b0;
		repeat (2) @(negedge iCLOCK);
		inRESET = 1'b1;
		@(negedge iCLOCK);
		check_value("stall", stall, 1'b0);
		check_value("out_valid", out_valid, 1'b0);
		check_value("mem_req", mem_req, 1'b0);
		check_value("fault_valid", fault_valid, 1'b0);
		integer_burst(N_INT);
		for (int i = 0; i < N_DIV; i++) begin
			a = $urandom;
			b = (i % 3 == 0) ? $urandom : $urandom_range(1, 300);
			if (i % 2 == 1) begin
				b = -b;
			end
			if (b == 0) begin
				b = 32'd1;
			end
			divide_once(exe_pkg::cmd_e'(i % 4), a, b);
		end
		for (int i = 0; i < N_MEM; i++) begin
			store_then_load();
		end
		fault_cases();
		for (int i = 0; i < N_FLUSH; i++) begin
			flush_division();
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end
		else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
hw/exe_pkg.sv
hw/exe_ifs.sv
hw/operand_forward.sv
hw/int_unit.sv
hw/radix2_divider.sv
hw/exe_control.sv
hw/exe_stage.sv
tb/exe_tb_pkg.sv
tb/tb_exe.sv

//--- Bender.yml
package:
  name: exe_stage

export_include_dirs:
  - include

sources:
  - hw/exe_pkg.sv
  - hw/exe_ifs.sv
  - hw/operand_forward.sv
  - hw/int_unit.sv
  - hw/radix2_divider.sv
  - hw/exe_control.sv
  - hw/exe_stage.sv
  - target: test
    files:
      - tb/exe_tb_pkg.sv
      - tb/tb_exe.sv
